// File: verilog/rvCfg.svh
/* core configuration */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data word and address width
`define RV_XLEN 32

`define RV_REG_COUNT 32

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// model memory depth in words
`define RV_MEM_WORDS 256

`endif

// File: verilog/rvPkg.sv
/* core types */
`include "rvCfg.svh"

package rvPkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_REG_COUNT)-1:0] regAddr_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		RType = 7'b0110011,
		ITypeLogic = 7'b0010011,
		ITypeLoad = 7'b0000011,
		SType = 7'b0100011,
		BType = 7'b1100011,
		JType = 7'b1101111,
		UTypeLui = 7'b0110111,
		UTypeAuipc = 7'b0010111
	} opcode_t;

	typedef enum logic [1:0] {aluAdd, aluSubCmp, aluRFunct, aluIFunct} aluOp_t;

	typedef enum logic {adrPc, adrAluOut} adrSrc_t;
	typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARd1, srcAZero} aluSrcA_t;
	typedef enum logic [1:0] {srcBRd2, srcBImm, srcBFour} aluSrcB_t;
	typedef enum logic [1:0] {resultAluOut, resultData, resultAlu} resultSrc_t;
	typedef enum logic {pcIncrement, pcJump} pcSrc_t;
	typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSrc_t;

	// control states, wait states close each memory handshake
	typedef enum logic [3:0] {
		fetch, fetchWait, decode, executeR,
		executeI, unconditionalJump, lui, auipc,
		memAdr, memRead, memReadWait, memWrite,
		memWriteWait, aluWriteback, memWriteback, branchIfEqual
	} fsmState_t;

endpackage

// File: verilog/controlFsm.sv
/* multicycle control FSM */
`timescale 1ns/100ps

module controlFsm (
	input logic clk,
	input logic reset,
	input rvPkg::opcode_t opcode,
	input logic zeroFlag,
	input logic memAck,
	output logic memReq,
	output logic memWe,
	output logic irWrite,
	output logic regWrite,
	output logic pcUpdate,
	output rvPkg::adrSrc_t adrSrc,
	output rvPkg::aluSrcA_t aluSrcA,
	output rvPkg::aluSrcB_t aluSrcB,
	output rvPkg::aluOp_t aluOp,
	output rvPkg::resultSrc_t resultSrc,
	output rvPkg::pcSrc_t pcSrc,
	output rvPkg::immSrc_t immSrc
);
	import rvPkg::*;

	fsmState_t state, nextState;

	always_comb begin
		nextState = state;
		case (state)
			fetch: if (memAck) nextState = fetchWait;
			fetchWait: if (!memAck) nextState = decode;
			decode: begin
				case (opcode)
					RType: nextState = executeR;
					ITypeLogic: nextState = executeI;
					ITypeLoad, SType: nextState = memAdr;
					BType: nextState = branchIfEqual;
					JType: nextState = unconditionalJump;
					UTypeLui: nextState = lui;
					UTypeAuipc: nextState = auipc;
					// unknown opcode, pc already points past it
					default: nextState = fetch;
				endcase
			end
			executeR, executeI, unconditionalJump, lui, auipc: nextState = aluWriteback;
			memAdr: nextState = (opcode == ITypeLoad) ? memRead : memWrite;
			memRead: if (memAck) nextState = memWriteback;
			// data register already holds the word here
			memWriteback: nextState = memReadWait;
			memReadWait: if (!memAck) nextState = fetch;
			memWrite: if (memAck) nextState = memWriteWait;
			memWriteWait: if (!memAck) nextState = fetch;
			default: nextState = fetch;
		endcase
	end

	// request lines follow the next state so they start clean after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetch;
			memReq <= 1'b0;
			memWe <= 1'b0;
		end else begin
			state <= nextState;
			memReq <= nextState inside {fetch, memRead, memWrite};
			memWe <= (nextState == memWrite);
		end
	end

	always_comb begin
		adrSrc = adrPc;
		aluSrcA = srcAPc;
		aluSrcB = srcBFour;
		aluOp = aluAdd;
		resultSrc = resultAluOut;
		pcSrc = pcIncrement;
		irWrite = 1'b0;
		regWrite = 1'b0;
		pcUpdate = 1'b0;
		case (state)
			// pc + 4 is computed while the instruction comes back
			fetch: begin
				irWrite = memAck;
				pcUpdate = memAck;
			end
			decode: begin
				aluSrcA = srcAOldPc;
				aluSrcB = srcBImm;
			end
			executeR: begin
				aluSrcA = srcARd1;
				aluSrcB = srcBRd2;
				aluOp = aluRFunct;
			end
			executeI: begin
				aluSrcA = srcARd1;
				aluSrcB = srcBImm;
				aluOp = aluIFunct;
			end
			unconditionalJump: begin
				aluSrcA = srcAOldPc;
				pcSrc = pcJump;
				pcUpdate = 1'b1;
			end
			lui: begin
				aluSrcA = srcAZero;
				aluSrcB = srcBImm;
			end
			auipc: begin
				aluSrcA = srcAOldPc;
				aluSrcB = srcBImm;
			end
			// address is recomputed each cycle to keep aluOut steady
			memAdr, memRead, memWrite: begin
				adrSrc = (state == memAdr) ? adrPc : adrAluOut;
				aluSrcA = srcARd1;
				aluSrcB = srcBImm;
			end
			branchIfEqual: begin
				aluSrcA = srcARd1;
				aluSrcB = srcBRd2;
				aluOp = aluSubCmp;
				pcSrc = pcJump;
				pcUpdate = zeroFlag;
			end
			aluWriteback: regWrite = 1'b1;
			memWriteback: begin
				resultSrc = resultData;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

	// immediate format follows the opcode, valid from decode onward
	always_comb begin
		case (opcode)
			SType: immSrc = immS;
			BType: immSrc = immB;
			JType: immSrc = immJ;
			UTypeLui, UTypeAuipc: immSrc = immU;
			default: immSrc = immI;
		endcase
	end

	// request held until acknowledged
	assert property (@(posedge clk) disable iff (reset) memReq && !memAck |=> memReq);
	// no new request before the memory releases ack
	assert property (@(posedge clk) disable iff (reset) !memReq && memAck |=> !memReq);
	assert property (@(posedge clk) disable iff (reset) memWe |-> memReq);

endmodule

// File: verilog/alu.sv
/* integer ALU */
`timescale 1ns/100ps

module alu (
	input rvPkg::word_t a,
	input rvPkg::word_t b,
	input rvPkg::aluOp_t aluOp,
	input logic [2:0] funct3,
	input logic funct7b5,
	output rvPkg::word_t result,
	output logic zero
);
	import rvPkg::*;

	logic [2:0] fn;
	logic subtract;
	logic lessThan;
	word_t sum;

	// address and compare classes run on the adder alone
	always_comb begin
		fn = 3'b000;
		subtract = 1'b0;
		case (aluOp)
			aluSubCmp: subtract = 1'b1;
			aluRFunct: begin
				fn = funct3;
				subtract = funct7b5 && (funct3 == 3'b000);
			end
			// no sub among the immediate forms
			aluIFunct: fn = funct3;
			default: fn = 3'b000;
		endcase
	end

	assign sum = subtract ? a - b : a + b;
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (fn)
			3'b010: result = word_t'(lessThan);
			3'b100: result = a ^ b;
			3'b110: result = a | b;
			3'b111: result = a & b;
			default: result = sum;
		endcase
	end

	// used by beq after a subtract
	assign zero = (result == '0);

endmodule

// File: verilog/registerFile.sv
/* register file */
`timescale 1ns/100ps
`include "rvCfg.svh"

module registerFile (
	input logic clk,
	input rvPkg::regAddr_t readAddr1,
	input rvPkg::regAddr_t readAddr2,
	input rvPkg::regAddr_t writeAddr,
	input logic writeEnable,
	input rvPkg::word_t writeData,
	output rvPkg::word_t readData1,
	output rvPkg::word_t readData2
);
	import rvPkg::*;

	word_t regs [`RV_REG_COUNT];

	always_ff @(posedge clk) begin
		if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	// x0 is hardwired
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

	// a written value reads back next cycle, except at x0 which stays zero
	assert property (@(posedge clk)
		writeEnable ##1 (readAddr1 == $past(writeAddr)) |->
			readData1 == (($past(writeAddr) == '0) ? '0 : $past(writeData)));

endmodule

// File: verilog/immExtend.sv
/* immediate extender */
`timescale 1ns/100ps
`include "rvCfg.svh"

module immExtend (
	input logic [`RV_XLEN-1:7] instr,
	input rvPkg::immSrc_t immSrc,
	output rvPkg::word_t immExt
);
	import rvPkg::*;

	always_comb begin
		case (immSrc)
			immS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			// branch offsets are in half words
			immB: immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			immJ: immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			immU: immExt = {instr[31:12], 12'b0};
			default: immExt = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

// File: verilog/datapath.sv
/* multicycle datapath */
`timescale 1ns/100ps
`include "rvCfg.svh"

module datapath (
	input logic clk,
	input logic reset,
	input rvPkg::adrSrc_t adrSrc,
	input rvPkg::aluSrcA_t aluSrcA,
	input rvPkg::aluSrcB_t aluSrcB,
	input rvPkg::aluOp_t aluOp,
	input rvPkg::resultSrc_t resultSrc,
	input rvPkg::pcSrc_t pcSrc,
	input rvPkg::immSrc_t immSrc,
	input logic irWrite,
	input logic regWrite,
	input logic pcUpdate,
	input rvPkg::word_t memRdata,
	output rvPkg::opcode_t opcode,
	output logic zeroFlag,
	output rvPkg::word_t memAddr,
	output rvPkg::word_t memWdata
);
	import rvPkg::*;

	word_t pc, oldPc, instr;
	word_t regA, regB, aluOut, dataReg;
	word_t readData1, readData2, immExt;
	word_t srcA, srcB, aluResult, result;

	// jal and taken beq load the target left in aluOut
	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RV_RESET_PC;
		else if (pcUpdate)
			pc <= (pcSrc == pcJump) ? aluOut : aluResult;
	end

	always_ff @(posedge clk) begin
		if (irWrite) begin
			oldPc <= pc;
			instr <= memRdata;
		end
		regA <= readData1;
		regB <= readData2;
		aluOut <= aluResult;
		dataReg <= memRdata;
	end

	assign opcode = opcode_t'(instr[6:0]);
	assign memAddr = (adrSrc == adrAluOut) ? aluOut : pc;
	assign memWdata = regB;

	registerFile regFile (
		.clk(clk),
		.readAddr1(instr[19:15]),
		.readAddr2(instr[24:20]),
		.writeAddr(instr[11:7]),
		.writeEnable(regWrite),
		.writeData(result),
		.readData1(readData1),
		.readData2(readData2)
	);

	immExtend immGen (
		.instr(instr[31:7]),
		.immSrc(immSrc),
		.immExt(immExt)
	);

	always_comb begin
		case (aluSrcA)
			srcAOldPc: srcA = oldPc;
			srcARd1: srcA = regA;
			srcAZero: srcA = '0;
			default: srcA = pc;
		endcase
	end

	always_comb begin
		case (aluSrcB)
			srcBRd2: srcB = regB;
			srcBImm: srcB = immExt;
			default: srcB = 32'd4;
		endcase
	end

	alu aluUnit (
		.a(srcA),
		.b(srcB),
		.aluOp(aluOp),
		.funct3(instr[14:12]),
		.funct7b5(instr[30]),
		.result(aluResult),
		.zero(zeroFlag)
	);

	// writeback value
	always_comb begin
		case (resultSrc)
			resultData: result = dataReg;
			resultAlu: result = aluResult;
			default: result = aluOut;
		endcase
	end

	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: verilog/rvCore.sv
/* RV32I multicycle core */
`timescale 1ns/100ps

module rvCore (
	input logic clk,
	input logic reset,
	input logic memAck,
	input rvPkg::word_t memRdata,
	output logic memReq,
	output logic memWe,
	output rvPkg::word_t memAddr,
	output rvPkg::word_t memWdata
);
	import rvPkg::*;

	opcode_t opcode;
	logic zeroFlag;
	logic irWrite, regWrite, pcUpdate;
	adrSrc_t adrSrc;
	aluSrcA_t aluSrcA;
	aluSrcB_t aluSrcB;
	aluOp_t aluOp;
	resultSrc_t resultSrc;
	pcSrc_t pcSrc;
	immSrc_t immSrc;

	controlFsm control (
		.clk, .reset, .opcode, .zeroFlag, .memAck,
		.memReq, .memWe, .irWrite, .regWrite, .pcUpdate,
		.adrSrc, .aluSrcA, .aluSrcB, .aluOp, .resultSrc, .pcSrc, .immSrc
	);

	datapath dp (
		.clk, .reset,
		.adrSrc, .aluSrcA, .aluSrcB, .aluOp, .resultSrc, .pcSrc, .immSrc,
		.irWrite, .regWrite, .pcUpdate,
		.memRdata, .opcode, .zeroFlag, .memAddr, .memWdata
	);

endmodule

// File: tests/clockGen.sv
/* testbench clock and reset */
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic reset
);
	initial clk = 1'b0;

	// 40 ns period
	always #20 clk = ~clk;

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		#2 reset = 1'b0;
	end

endmodule

// File: tests/memoryModel.sv
/* shared memory model */
`timescale 1ns/100ps
`include "rvCfg.svh"

module memoryModel (
	input logic clk,
	input logic memReq,
	input logic memWe,
	input rvPkg::word_t memAddr,
	input rvPkg::word_t memWdata,
	output logic memAck,
	output rvPkg::word_t memRdata
);
	import rvPkg::*;

	localparam int indexBits = $clog2(`RV_MEM_WORDS);

	// contents are loaded by the testbench before reset ends
	word_t mem [`RV_MEM_WORDS];
	int unsigned waitCycles;

	initial begin
		memAck = 1'b0;
		memRdata = '0;
		// seed this process once
		waitCycles = $urandom(32);
		forever begin
			@(posedge clk);
			if (memReq) begin
				waitCycles = $urandom % 6;
				repeat (waitCycles) @(posedge clk);
				#2;
				if (memWe)
					mem[memAddr[indexBits+1:2]] = memWdata;
				else
					memRdata = mem[memAddr[indexBits+1:2]];
				memAck = 1'b1;
				// hold ack until the core drops its request
				do
					@(posedge clk);
				while (memReq);
				#2;
				memAck = 1'b0;
			end
		end
	end

endmodule

// File: tests/rvCoreTb.sv
/* RV32I core testbench */
`timescale 1ns/100ps
`include "rvCfg.svh"

module rvCoreTb;
	import rvPkg::*;

	localparam word_t resultBase = 32'h0000_0300;
	localparam word_t doneAddr = 32'h0000_03FC;
	localparam word_t dataAddr = 32'h0000_0200;
	localparam word_t dataWord = 32'h1357_9BDF;
	// two memory handshakes of up to 9 cycles plus the single-cycle steps
	localparam int maxInstr = 40;
	localparam int cyclesPerInstr = 24;
	localparam time watchdogTime = (16 + maxInstr * cyclesPerInstr) * 40;

	logic clk, reset, memReq, memWe, memAck;
	word_t memAddr, memWdata, memRdata;

	word_t programWords[$];
	word_t expAddr[$];
	word_t expData[$];
	int storeIdx = 0;
	logic firstReqSeen = 1'b0;
	logic doneSeen = 1'b0;
	logic prevReq, prevAck, prevWe;
	word_t prevAddr, prevWdata;

	clockGen clkGen (.clk, .reset);

	memoryModel memModel (.clk, .memReq, .memWe, .memAddr, .memWdata, .memAck, .memRdata);

	rvCore UUT (.clk, .reset, .memAck, .memRdata, .memReq, .memWe, .memAddr, .memWdata);

	task automatic failValue(input string name, input word_t got, input word_t exp);
		$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
		$display("TB FAILED");
		$fatal(1, "check on %s", name);
	endtask

	task automatic failText(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	// RV32I instruction encoders
	function automatic word_t encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic word_t encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic word_t encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic word_t encJ(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
	endfunction

	function automatic word_t encU(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	task automatic emit(input word_t instr);
		programWords.push_back(instr);
	endtask

	// sw rs2 to resultBase + offset, with the value it must carry
	task automatic storeChecked(input logic [4:0] rs2, input logic [11:0] offset,
			input word_t value);
		emit(encS(offset, rs2, 5'd1));
		expAddr.push_back(resultBase + offset);
		expData.push_back(value);
	endtask

	task automatic buildProgram();
		word_t auipcPc;
		word_t jalPc;
		emit(encI(12'h300, 0, 3'b000, 1, 7'h13));
		emit(encI(12'd25, 0, 3'b000, 2, 7'h13));
		emit(encI(12'hFF9, 0, 3'b000, 3, 7'h13));
		emit(encI(12'h5A5, 0, 3'b000, 14, 7'h13));
		// x2 = 25, x3 = -7
		emit(encR(7'h00, 3, 2, 3'b000, 4));
		storeChecked(4, 12'h000, 32'd18);
		emit(encR(7'h20, 3, 2, 3'b000, 5));
		storeChecked(5, 12'h004, 32'd32);
		emit(encR(7'h00, 3, 2, 3'b111, 6));
		storeChecked(6, 12'h008, 32'h0000_0019);
		emit(encR(7'h00, 3, 2, 3'b110, 7));
		storeChecked(7, 12'h00C, 32'hFFFF_FFF9);
		emit(encR(7'h00, 3, 2, 3'b100, 8));
		storeChecked(8, 12'h010, 32'hFFFF_FFE0);
		emit(encR(7'h00, 2, 3, 3'b010, 9));
		storeChecked(9, 12'h014, 32'd1);
		emit(encI(12'h00F, 2, 3'b111, 10, 7'h13));
		storeChecked(10, 12'h018, 32'd9);
		emit(encI(12'h100, 2, 3'b110, 10, 7'h13));
		storeChecked(10, 12'h01C, 32'h0000_0119);
		emit(encI(12'hFFF, 2, 3'b100, 10, 7'h13));
		storeChecked(10, 12'h020, 32'hFFFF_FFE6);
		emit(encI(12'hFFA, 3, 3'b010, 10, 7'h13));
		storeChecked(10, 12'h024, 32'd1);
		emit(encU(20'h12345, 11, 7'h37));
		storeChecked(11, 12'h028, 32'h1234_5000);
		auipcPc = programWords.size() * 4;
		emit(encU(20'h00001, 12, 7'h17));
		storeChecked(12, 12'h02C, auipcPc + 32'h0000_1000);
		emit(encI(dataAddr[11:0], 0, 3'b010, 13, 7'h03));
		emit(encI(12'h123, 13, 3'b000, 13, 7'h13));
		storeChecked(13, 12'h030, dataWord + 32'h123);
		// taken beq jumps over the marker store
		emit(encB(13'd8, 2, 2));
		emit(encS(12'h034, 14, 1));
		emit(encB(13'd8, 3, 2));
		storeChecked(14, 12'h034, 32'h0000_05A5);
		jalPc = programWords.size() * 4;
		emit(encJ(21'd8, 15));
		emit(encS(12'h038, 14, 1));
		storeChecked(15, 12'h038, jalPc + 4);
		emit(encS(doneAddr[11:0] - resultBase[11:0], 2, 1));
		emit(encJ(21'd0, 0));
	endtask

	initial begin
		buildProgram();
		for (int i = 0; i < `RV_MEM_WORDS; i++)
			memModel.mem[i] = 32'hBAD0_0000 | (i << 2);
		memModel.mem[dataAddr >> 2] = dataWord;
		for (int i = 0; i < programWords.size(); i++)
			memModel.mem[i] = programWords[i];
		wait (doneSeen);
		if (storeIdx == expAddr.size()) begin
			$display("TB PASSED");
			$finish;
		end else begin
			failText("done store came before all expected stores");
		end
	end

	initial begin
		#(watchdogTime);
		failText("timeout, the program never stored to the done address");
	end

	assert property (@(posedge clk) $fell(reset) |-> !memReq)
		else failValue("memReq", $sampled(memReq), 0);
	assert property (@(posedge clk) $fell(reset) |-> !memWe)
		else failValue("memWe", $sampled(memWe), 0);

	// port values at the edge, before the core updates them
	always @(posedge clk) begin
		if (!reset) begin
			if (!firstReqSeen && memReq) begin
				firstReqSeen = 1'b1;
				assert (memAddr == `RV_RESET_PC) else failValue("memAddr", memAddr, `RV_RESET_PC);
				assert (!memWe) else failValue("memWe", memWe, 0);
			end
			if (prevReq && !prevAck) begin
				assert (memReq) else failText("memReq dropped before memAck rose");
				assert (memAddr == prevAddr) else failValue("memAddr", memAddr, prevAddr);
				assert (memWe == prevWe) else failValue("memWe", memWe, prevWe);
				assert (memWdata === prevWdata) else failValue("memWdata", memWdata, prevWdata);
			end
			if (!prevReq && prevAck)
				assert (!memReq) else failText("memReq raised while memAck was still high");
			if (memReq && memAck && memWe) begin
				if (memAddr == doneAddr) begin
					doneSeen = 1'b1;
				end else begin
					assert (storeIdx < expAddr.size()) else failText("more stores than expected");
					assert (memAddr == expAddr[storeIdx])
						else failValue("memAddr", memAddr, expAddr[storeIdx]);
					assert (memWdata == expData[storeIdx])
						else failValue("memWdata", memWdata, expData[storeIdx]);
					storeIdx++;
				end
			end
		end
		prevReq = memReq;
		prevAck = memAck;
		prevWe = memWe;
		prevAddr = memAddr;
		prevWdata = memWdata;
	end

endmodule

// File: filelist.f
+incdir+verilog
verilog/rvPkg.sv
verilog/controlFsm.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/immExtend.sv
verilog/datapath.sv
verilog/rvCore.sv
tests/clockGen.sv
tests/memoryModel.sv
tests/rvCoreTb.sv
